/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_scatter
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Simulation passed

SOURCES := $(wildcard *.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* array_zero_mask.sv */
`timescale 1ns/1ps

module array_zero_mask import scatter_pkg::*; (
    input  tensor_vec_t data,
    input  mask_t       mask,
    output split_vec_t  split
);

    always_comb begin
        split = '0;
        for (int i = 0; i < TENSOR_SIZE; i++) begin
            // Each element lands in exactly one lane
            if (mask[i]) begin
                split.high.elem[i] = data.elem[i];
            end else begin
                split.low.elem[i] = data.elem[i];
            end
        end
    end

endmodule

/* block_ctrl.sv */
`timescale 1ns/1ps

module block_ctrl import scatter_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic in_valid,
    input  logic last_vec,
    output logic accept,
    output logic busy,
    output logic stats_clear,
    output logic block_done
);

    block_state_t state;
    block_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                // A one-vector block skips RUN
                if (last_vec) begin
                    state_next = DRAIN;
                end else if (accept) begin
                    state_next = RUN;
                end
            end
            RUN: begin
                if (last_vec) begin
                    state_next = DRAIN;
                end
            end
            // Last grant info reaches the stats here
            DRAIN:   state_next = REPORT;
            REPORT:  state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign busy   = (state == DRAIN) || (state == REPORT);
    assign accept = in_valid && !busy;

    // Totals are final in REPORT, cleared on the following edge
    assign block_done  = (state == REPORT);
    assign stats_clear = (state == REPORT);

endmodule

/* filelist.f */
scatter_pkg.sv
priority_encoder.sv
array_zero_mask.sv
scatter_threshold.sv
vector_counter.sv
block_ctrl.sv
outlier_stats.sv
scatter_top.sv
tb_scatter.sv

/* outlier_stats.sv */
`timescale 1ns/1ps

module outlier_stats import scatter_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        out_valid,
    input  grant_info_t info,
    input  logic        stats_clear,
    output count_t      block_kept,
    output count_t      block_dropped
);

    count_t kept_acc;
    count_t dropped_acc;

    always_ff @(posedge clk) begin
        if (reset) begin
            kept_acc    <= '0;
            dropped_acc <= '0;
        end else if (stats_clear) begin
            // Start of a new block
            kept_acc    <= '0;
            dropped_acc <= '0;
        end else if (out_valid) begin
            kept_acc    <= kept_acc + info.kept;
            dropped_acc <= dropped_acc + info.dropped;
        end
    end

    assign block_kept    = kept_acc;
    assign block_dropped = dropped_acc;

endmodule

/* priority_encoder.sv */
`timescale 1ns/1ps

module priority_encoder import scatter_pkg::*; #(
    parameter int HIGH_SLOTS = 2,
    parameter int DESIGN     = 1
) (
    input  mask_t       req,
    output mask_t       grant,
    output grant_info_t info
);

    // DESIGN 2 walks from the top index down
    localparam bit SCAN_DOWN = (DESIGN == 2);

    logic [IDX_W-1:0] idx;
    count_t           kept_cnt;
    count_t           drop_cnt;

    always_comb begin
        grant    = '0;
        kept_cnt = '0;
        drop_cnt = '0;
        idx      = '0;
        for (int i = 0; i < TENSOR_SIZE; i++) begin
            if (SCAN_DOWN) begin
                idx = IDX_W'(TENSOR_SIZE - 1 - i);
            end else begin
                idx = IDX_W'(i);
            end
            if (req[idx]) begin
                // Grant while slots remain, the rest are dropped
                if (kept_cnt < count_t'(HIGH_SLOTS)) begin
                    grant[idx] = 1'b1;
                    kept_cnt   = kept_cnt + 1'b1;
                end else begin
                    drop_cnt = drop_cnt + 1'b1;
                end
            end
        end
    end

    assign info = '{kept: kept_cnt, dropped: drop_cnt};

endmodule

/* scatter_pkg.sv */
package scatter_pkg;

    // Element and vector geometry
    localparam int ELEM_W      = 8;
    localparam int TENSOR_SIZE = 4;
    localparam int IDX_W       = $clog2(TENSOR_SIZE);

    // One signed tensor element
    typedef logic signed [ELEM_W-1:0] elem_t;

    // One bit per element position
    typedef logic [TENSOR_SIZE-1:0] mask_t;

    // Outlier count, sized for a block of up to 63 vectors
    typedef logic [7:0] count_t;

    // Element 0 sits in the low bits
    typedef struct packed {
        elem_t [TENSOR_SIZE-1:0] elem;
    } tensor_vec_t;

    // High and low precision lanes of one vector
    typedef struct packed {
        tensor_vec_t high;
        tensor_vec_t low;
    } split_vec_t;

    // Per-vector outlier outcome
    typedef struct packed {
        count_t kept;
        count_t dropped;
    } grant_info_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN,
        REPORT
    } block_state_t;

endpackage

/* scatter_threshold.sv */
`timescale 1ns/1ps

module scatter_threshold import scatter_pkg::*; #(
    parameter int THRESHOLD  = 6,
    parameter int HIGH_SLOTS = 2,
    parameter int DESIGN     = 1
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        accept,
    input  tensor_vec_t data_in,
    output logic        out_valid,
    output split_vec_t  data_out,
    output grant_info_t info
);

    mask_t       outlier_req;
    mask_t       grant;
    grant_info_t grant_info;
    split_vec_t  split;

    // Outlier when strictly beyond +/- THRESHOLD
    always_comb begin
        for (int i = 0; i < TENSOR_SIZE; i++) begin
            outlier_req[i] = ($signed(data_in.elem[i]) > THRESHOLD) ||
                             ($signed(data_in.elem[i]) < -THRESHOLD);
        end
    end

    priority_encoder #(
        .HIGH_SLOTS (HIGH_SLOTS),
        .DESIGN     (DESIGN)
    ) u_encoder (
        .req   (outlier_req),
        .grant (grant),
        .info  (grant_info)
    );

    array_zero_mask u_masker (
        .data  (data_in),
        .mask  (grant),
        .split (split)
    );

    // Output register, one vector per cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            data_out  <= '0;
            info      <= '0;
        end else begin
            out_valid <= accept;
            if (accept) begin
                data_out <= split;
                info     <= grant_info;
            end
        end
    end

endmodule

/* scatter_top.sv */
`timescale 1ns/1ps

module scatter_top import scatter_pkg::*; #(
    parameter int THRESHOLD  = 6,
    parameter int HIGH_SLOTS = 2,
    parameter int DESIGN     = 1,
    parameter int BLOCK_LEN  = 8
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    input  tensor_vec_t data_in,
    output logic        out_valid,
    output split_vec_t  data_out,
    output logic        busy,
    output logic        block_done,
    output count_t      block_kept,
    output count_t      block_dropped
);

    logic        accept;
    logic        last_vec;
    logic        stats_clear;
    grant_info_t grant_info;

    block_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .last_vec    (last_vec),
        .accept      (accept),
        .busy        (busy),
        .stats_clear (stats_clear),
        .block_done  (block_done)
    );

    vector_counter #(
        .BLOCK_LEN (BLOCK_LEN)
    ) u_counter (
        .clk      (clk),
        .reset    (reset),
        .accept   (accept),
        .last_vec (last_vec)
    );

    // Outlier split datapath
    scatter_threshold #(
        .THRESHOLD  (THRESHOLD),
        .HIGH_SLOTS (HIGH_SLOTS),
        .DESIGN     (DESIGN)
    ) u_scatter (
        .clk       (clk),
        .reset     (reset),
        .accept    (accept),
        .data_in   (data_in),
        .out_valid (out_valid),
        .data_out  (data_out),
        .info      (grant_info)
    );

    outlier_stats u_stats (
        .clk           (clk),
        .reset         (reset),
        .out_valid     (out_valid),
        .info          (grant_info),
        .stats_clear   (stats_clear),
        .block_kept    (block_kept),
        .block_dropped (block_dropped)
    );

endmodule

/* tb_scatter.sv */
`timescale 1ns/1ps

module tb_scatter import scatter_pkg::*; ();

    localparam int THRESH     = 6;
    localparam int SLOTS      = 2;
    localparam int BLOCK_LEN  = 8;
    localparam int RAND_VECS  = 32;
    localparam int BLOCKS_EXP = 1 + RAND_VECS / BLOCK_LEN;

    logic        clk;
    logic        reset;
    logic        in_valid;
    tensor_vec_t data_in;
    logic        out_valid;
    split_vec_t  data_out;
    logic        busy;
    logic        block_done;
    count_t      block_kept;
    count_t      block_dropped;

    logic [31:0] lfsr_state;
    int          done_seen;

    // Reference model state
    int          m_phase;
    int          m_count;
    logic        m_valid;
    split_vec_t  m_data;
    tensor_vec_t m_in;
    count_t      m_run_kept;
    count_t      m_run_dropped;
    count_t      m_blk_kept;
    count_t      m_blk_dropped;
    logic        m_done_q;
    logic        m_rst_q;
    logic        m_busy;
    logic        m_done;
    logic        m_accept;

    scatter_top scatter_top_i (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .data_in       (data_in),
        .out_valid     (out_valid),
        .data_out      (data_out),
        .busy          (busy),
        .block_done    (block_done),
        .block_kept    (block_kept),
        .block_dropped (block_dropped)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input logic [63:0] exp,
                                input logic [63:0] act);
        fail_run($sformatf("ERROR: time %0t signal %s expected 0x%0h actual 0x%0h",
                           $time, name, exp, act));
    endtask

    // x^32 + x^22 + x^2 + x + 1, one new bit per step
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    // Mix of small values and full range values
    function automatic elem_t random_elem();
        logic [31:0] r;
        elem_t       e;
        r = next_bits(1);
        if (r[0]) begin
            r = next_bits(4);
            e = {{4{r[3]}}, r[3:0]};
        end else begin
            r = next_bits(8);
            e = r[7:0];
        end
        return e;
    endfunction

    function automatic tensor_vec_t make_vec(input int e0, input int e1,
                                             input int e2, input int e3);
        tensor_vec_t v;
        v.elem[0] = elem_t'(e0);
        v.elem[1] = elem_t'(e1);
        v.elem[2] = elem_t'(e2);
        v.elem[3] = elem_t'(e3);
        return v;
    endfunction

    function automatic bit is_outlier(input elem_t e);
        return (int'(e) > THRESH) || (int'(e) < -THRESH);
    endfunction

    function automatic int outlier_total(input tensor_vec_t v);
        int n;
        n = 0;
        for (int i = 0; i < TENSOR_SIZE; i++) begin
            if (is_outlier(v.elem[i])) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic count_t kept_of(input tensor_vec_t v);
        return count_t'((outlier_total(v) > SLOTS) ? SLOTS : outlier_total(v));
    endfunction

    function automatic count_t dropped_of(input tensor_vec_t v);
        return count_t'(outlier_total(v)) - kept_of(v);
    endfunction

    // Lowest index outliers win the high lane
    function automatic split_vec_t expected_split(input tensor_vec_t v);
        split_vec_t s;
        int         granted;
        s       = '0;
        granted = 0;
        for (int i = 0; i < TENSOR_SIZE; i++) begin
            if (is_outlier(v.elem[i]) && granted < SLOTS) begin
                s.high.elem[i] = v.elem[i];
                granted++;
            end else begin
                s.low.elem[i] = v.elem[i];
            end
        end
        return s;
    endfunction

    function automatic bit lanes_ok(input split_vec_t s, input tensor_vec_t v);
        bit ok;
        ok = 1'b1;
        for (int i = 0; i < TENSOR_SIZE; i++) begin
            if (int'(s.high.elem[i]) + int'(s.low.elem[i]) != int'(v.elem[i])) begin
                ok = 1'b0;
            end
            if (s.high.elem[i] != 0 && s.low.elem[i] != 0) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    // Phase 1 is the drain cycle, phase 2 the report cycle
    assign m_busy   = (m_phase != 0);
    assign m_done   = (m_phase == 2);
    assign m_accept = in_valid && !m_busy;

    always @(posedge clk) begin
        if (reset) begin
            m_phase       <= 0;
            m_count       <= 0;
            m_valid       <= 1'b0;
            m_data        <= '0;
            m_in          <= '0;
            m_run_kept    <= '0;
            m_run_dropped <= '0;
            m_blk_kept    <= '0;
            m_blk_dropped <= '0;
            m_done_q      <= 1'b0;
            m_rst_q       <= 1'b1;
        end else begin
            m_rst_q  <= 1'b0;
            m_done_q <= m_done;
            m_valid  <= m_accept;
            if (m_phase == 1) begin
                m_phase <= 2;
            end else if (m_phase == 2) begin
                m_phase <= 0;
            end
            if (m_accept) begin
                m_data <= expected_split(data_in);
                m_in   <= data_in;
                if (m_count == BLOCK_LEN - 1) begin
                    m_phase       <= 1;
                    m_count       <= 0;
                    m_blk_kept    <= m_run_kept + kept_of(data_in);
                    m_blk_dropped <= m_run_dropped + dropped_of(data_in);
                    m_run_kept    <= '0;
                    m_run_dropped <= '0;
                end else begin
                    m_count       <= m_count + 1;
                    m_run_kept    <= m_run_kept + kept_of(data_in);
                    m_run_dropped <= m_run_dropped + dropped_of(data_in);
                end
            end
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            done_seen <= 0;
        end else if (block_done) begin
            done_seen <= done_seen + 1;
        end
    end

    a_reset_values: assert property (@(posedge clk) disable iff (reset)
        m_rst_q |-> (!out_valid && !busy && !block_done && block_kept == '0 &&
                     block_dropped == '0 && data_out == '0))
        else fail_run("Outputs were not at their reset values after reset");

    a_out_valid: assert property (@(posedge clk) disable iff (reset)
        out_valid == m_valid)
        else report_value("out_valid", 64'(m_valid), 64'(out_valid));

    a_busy: assert property (@(posedge clk) disable iff (reset)
        busy == m_busy)
        else report_value("busy", 64'(m_busy), 64'(busy));

    a_block_done: assert property (@(posedge clk) disable iff (reset)
        block_done == m_done)
        else report_value("block_done", 64'(m_done), 64'(block_done));

    a_data_out: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> data_out == m_data)
        else report_value("data_out", 64'(m_data), 64'(data_out));

    a_lanes: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> lanes_ok(data_out, m_in))
        else fail_run("Lanes of data_out do not add up to the input or both are nonzero");

    a_block_kept: assert property (@(posedge clk) disable iff (reset)
        block_done |-> block_kept == m_blk_kept)
        else report_value("block_kept", 64'(m_blk_kept), 64'(block_kept));

    a_block_dropped: assert property (@(posedge clk) disable iff (reset)
        block_done |-> block_dropped == m_blk_dropped)
        else report_value("block_dropped", 64'(m_blk_dropped), 64'(block_dropped));

    // Totals restart once the report cycle has passed
    a_kept_cleared: assert property (@(posedge clk) disable iff (reset)
        m_done_q |-> block_kept == '0)
        else report_value("block_kept", 64'(0), 64'(block_kept));

    a_dropped_cleared: assert property (@(posedge clk) disable iff (reset)
        m_done_q |-> block_dropped == '0)
        else report_value("block_dropped", 64'(0), 64'(block_dropped));

    task automatic idle_cycles(input int n);
        in_valid = 1'b0;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #2;
        end
    endtask

    // Junk outliers are offered while busy and must be ignored
    task automatic send_vector(input tensor_vec_t v);
        int waited;
        waited = 0;
        while (busy) begin
            in_valid = 1'b1;
            data_in  = make_vec(120, -120, 120, -120);
            @(posedge clk);
            #2;
            waited++;
            if (waited > 10) begin
                fail_run("busy stayed high for more than 10 cycles");
            end
        end
        in_valid = 1'b1;
        data_in  = v;
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    task automatic wait_block_done();
        int waited;
        waited = 0;
        while (!block_done) begin
            @(posedge clk);
            #2;
            waited++;
            if (waited > 20) begin
                fail_run("block_done did not pulse within 20 cycles");
            end
        end
    endtask

    initial begin
        tensor_vec_t v;
        logic [31:0] gap;
        lfsr_state = 32'h2404_e6be;
        reset      = 1'b1;
        in_valid   = 1'b0;
        data_in    = '0;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        idle_cycles(2);

        // Directed block
        send_vector(make_vec(1, -2, 3, 0));
        send_vector(make_vec(5, -5, 4, -3));
        send_vector(make_vec(100, -50, 7, -7));
        send_vector(make_vec(-128, 127, -100, 90));
        send_vector(make_vec(6, -6, 6, -6));
        send_vector(make_vec(7, 6, -7, -6));
        send_vector(make_vec(0, 0, -7, 8));
        send_vector(make_vec(-6, 9, -9, 10));

        // Random blocks with gaps in in_valid
        for (int n = 0; n < RAND_VECS; n++) begin
            gap = next_bits(2);
            idle_cycles(int'(gap));
            for (int i = 0; i < TENSOR_SIZE; i++) begin
                v.elem[i] = random_elem();
            end
            send_vector(v);
        end

        wait_block_done();
        idle_cycles(3);

        if (done_seen == BLOCKS_EXP) begin
            $display("Simulation passed");
            $finish;
        end else begin
            report_value("block_done pulse count", 64'(BLOCKS_EXP), 64'(done_seen));
        end
    end

endmodule

/* vector_counter.sv */
`timescale 1ns/1ps

module vector_counter #(
    parameter int BLOCK_LEN = 8
) (
    input  logic clk,
    input  logic reset,
    input  logic accept,
    output logic last_vec
);

    localparam int CNT_W = (BLOCK_LEN > 1) ? $clog2(BLOCK_LEN) : 1;

    // Index of the next vector within the block
    logic [CNT_W-1:0] vec_idx;

    assign last_vec = accept && (vec_idx == CNT_W'(BLOCK_LEN - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            vec_idx <= '0;
        end else if (last_vec) begin
            // Block complete, wrap
            vec_idx <= '0;
        end else if (accept) begin
            vec_idx <= vec_idx + 1'b1;
        end
    end

endmodule
